//--- files.f
+incdir+test
logic/biu_constants_pkg.sv
logic/biu_mem_pkg.sv
logic/biu_if.sv
logic/biu_mux.sv
logic/biu_sram.sv
logic/biu_mux_top.sv
test/biu_mux_tb.sv

//--- logic/biu_constants_pkg.sv
/*
  bus protocol encodings shared by every BIU master and slave
  size, burst type and protection enums, plus the burst length rule
  that the mux and the memory both need to count beats
*/
package biu_constants_pkg;

  // transfer size, the memory only serves WORD
  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010,
    DWORD = 3'b011,
    QWORD = 3'b100,
    OWORD = 3'b101
  } biu_size_t;

  // burst type
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,  // undefined length, handled as a single
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } biu_type_t;

  // protection flags, passed along untouched
  typedef enum logic [2:0] {
    PROT_DATA       = 3'b000,
    PROT_PRIVILEGED = 3'b001,
    PROT_NONSECURE  = 3'b010,
    PROT_INSTR      = 3'b100
  } biu_prot_t;

  // beats in a burst, minus one
  function automatic logic [3:0] biu_type2cnt(input biu_type_t btype);
    case (btype)
      WRAP4,  INCR4  : biu_type2cnt = 4'd3;
      WRAP8,  INCR8  : biu_type2cnt = 4'd7;
      WRAP16, INCR16 : biu_type2cnt = 4'd15;
      default        : biu_type2cnt = 4'd0;   // SINGLE and INCR
    endcase
  endfunction

endpackage

//--- logic/biu_if.sv
`timescale 1ns/1ps
/*
  one BIU link between a master and a slave
  master drives the request and write data, slave answers with strobes
*/
interface biu_if;
  import biu_constants_pkg::*;
  import biu_mem_pkg::*;

  // request side
  logic                 req;      // held until req_ack
  logic [ADDR_SIZE-1:0] adri;     // start address
  biu_size_t            size;
  biu_type_t            btype;    // burst type
  logic                 lock;
  biu_prot_t            prot;
  logic                 we;
  logic [DATA_SIZE-1:0] d;        // write data, advances on d_ack

  // response side
  logic                 req_ack;  // request taken
  logic                 d_ack;    // write data consumed
  logic [ADDR_SIZE-1:0] adro;     // beat address
  logic [DATA_SIZE-1:0] q;        // read data
  logic                 ack;      // one per beat
  logic                 err;      // failed beat, with ack

  modport master (output req, adri, size, btype, lock, prot, we, d,
                  input  req_ack, d_ack, adro, q, ack, err);

  modport slave  (input  req, adri, size, btype, lock, prot, we, d,
                  output req_ack, d_ack, adro, q, ack, err);

endinterface

//--- logic/biu_mem_pkg.sv
/*
  geometry of the memory subsystem
  bus widths, number of masters, memory depth and access latency
*/
package biu_mem_pkg;

  localparam int ADDR_SIZE  = 32;   // byte address
  localparam int DATA_SIZE  = 32;   // one word per beat
  localparam int PORTS      = 2;    // masters on the mux, port 0 wins

  // port index width, at least one bit
  localparam int PORT_SEL_W = (PORTS > 1) ? $clog2(PORTS) : 1;

  localparam int MEM_WORDS  = 256;  // depth in words, 1 KiB
  localparam int MEM_WAIT   = 1;    // idle cycles before first beat, >= 1

endpackage

//--- logic/biu_mux.sv
`timescale 1ns/1ps
/*
  fixed priority BIU multiplexer, lowest port wins
  steers the chosen master onto one outgoing link and keeps the burst
  owner until its last ack, so response strobes reach the right port
*/
module biu_mux
(
  input  logic  clk_i,
  input  logic  rst_ni,

  biu_if.slave  slv_i [biu_mem_pkg::PORTS],  // from the masters
  biu_if.master mst_o                        // towards the memory
);
  import biu_constants_pkg::*;
  import biu_mem_pkg::*;

  //////////////////////////////
  // per port request bundles

  logic                  req_p  [PORTS];
  logic [ADDR_SIZE-1:0]  adri_p [PORTS];
  biu_size_t             size_p [PORTS];
  biu_type_t             type_p [PORTS];
  logic                  lock_p [PORTS];
  biu_prot_t             prot_p [PORTS];
  logic                  we_p   [PORTS];
  logic [DATA_SIZE-1:0]  d_p    [PORTS];

  enum logic {IDLE = 1'b0, BURST = 1'b1} state;

  logic                  any_req;      // some port is asking
  logic [PORT_SEL_W-1:0] pend_port;    // winner by priority
  logic [PORT_SEL_W-1:0] owner_port;   // owns the burst in flight
  logic [PORT_SEL_W-1:0] d_port;       // source of write data
  logic [3:0]            burst_cnt;    // beats left, minus one
  logic                  last_ack;

  genvar p;

  generate
    for (p = 0; p < PORTS; p++)
    begin : g_port
      assign req_p[p]  = slv_i[p].req;
      assign adri_p[p] = slv_i[p].adri;
      assign size_p[p] = slv_i[p].size;
      assign type_p[p] = slv_i[p].btype;
      assign lock_p[p] = slv_i[p].lock;
      assign prot_p[p] = slv_i[p].prot;
      assign we_p[p]   = slv_i[p].we;
      assign d_p[p]    = slv_i[p].d;

      // accept goes to the winner, beat strobes to the owner
      assign slv_i[p].req_ack = (pend_port == PORT_SEL_W'(p))  ? mst_o.req_ack : 1'b0;
      assign slv_i[p].d_ack   = (owner_port == PORT_SEL_W'(p)) ? mst_o.d_ack   : 1'b0;
      assign slv_i[p].ack     = (owner_port == PORT_SEL_W'(p)) ? mst_o.ack     : 1'b0;
      assign slv_i[p].err     = (owner_port == PORT_SEL_W'(p)) ? mst_o.err     : 1'b0;
      assign slv_i[p].adro    = mst_o.adro;  // broadcast
      assign slv_i[p].q       = mst_o.q;
    end
  endgenerate

  //////////////////////////////
  // priority select

  always_comb
  begin
    any_req   = 1'b0;
    pend_port = '0;
    for (int n = PORTS - 1; n >= 0; n--)  // scan down, lowest wins
    begin
      if (req_p[n])
      begin
        any_req   = 1'b1;
        pend_port = PORT_SEL_W'(n);
      end
    end
  end

  assign last_ack = mst_o.ack & (burst_cnt == 4'd0);

  //////////////////////////////
  // burst tracking

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state      <= IDLE;
      burst_cnt  <= 4'd0;
      owner_port <= '0;
    end
    else
    begin
      case (state)
        IDLE:
          if (mst_o.req_ack)
          begin
            state      <= BURST;   // singles too, ack comes later
            owner_port <= pend_port;
            burst_cnt  <= biu_type2cnt(type_p[pend_port]);
          end
        BURST:
          if (mst_o.ack)
          begin
            if (burst_cnt != 4'd0)
              burst_cnt <= burst_cnt - 4'd1;
            else if (mst_o.req_ack)
            begin
              owner_port <= pend_port;  // back to back handover
              burst_cnt  <= biu_type2cnt(type_p[pend_port]);
            end
            else
              state <= IDLE;
          end
        default:
          state <= IDLE;
      endcase
    end
  end

  //////////////////////////////
  // outgoing link

  // new requests only pass when idle or on the last ack
  assign mst_o.req   = (state == IDLE) ? any_req : (last_ack & any_req);
  assign mst_o.adri  = adri_p[pend_port];
  assign mst_o.size  = size_p[pend_port];
  assign mst_o.btype = type_p[pend_port];
  assign mst_o.lock  = lock_p[pend_port];
  assign mst_o.prot  = prot_p[pend_port];
  assign mst_o.we    = we_p[pend_port];

  assign d_port  = (state == BURST) ? owner_port : pend_port;  // write beats follow the owner
  assign mst_o.d = d_p[d_port];

endmodule

//--- logic/biu_mux_top.sv
`timescale 1ns/1ps
/*
  memory access subsystem top level
  per port plain BIU signals are bundled into links, arbitrated by the
  mux and served by the on-chip word memory
*/
module biu_mux_top
(
  input  logic                              clk_i,
  input  logic                              rst_ni,

  input  logic                              req_i     [biu_mem_pkg::PORTS],
  output logic                              req_ack_o [biu_mem_pkg::PORTS],
  output logic                              d_ack_o   [biu_mem_pkg::PORTS],
  input  logic [biu_mem_pkg::ADDR_SIZE-1:0] adri_i    [biu_mem_pkg::PORTS],
  output logic [biu_mem_pkg::ADDR_SIZE-1:0] adro_o    [biu_mem_pkg::PORTS],
  input  biu_constants_pkg::biu_size_t      size_i    [biu_mem_pkg::PORTS],
  input  biu_constants_pkg::biu_type_t      type_i    [biu_mem_pkg::PORTS],
  input  logic                              lock_i    [biu_mem_pkg::PORTS],
  input  biu_constants_pkg::biu_prot_t      prot_i    [biu_mem_pkg::PORTS],
  input  logic                              we_i      [biu_mem_pkg::PORTS],
  input  logic [biu_mem_pkg::DATA_SIZE-1:0] d_i       [biu_mem_pkg::PORTS],
  output logic [biu_mem_pkg::DATA_SIZE-1:0] q_o       [biu_mem_pkg::PORTS],
  output logic                              ack_o     [biu_mem_pkg::PORTS],
  output logic                              err_o     [biu_mem_pkg::PORTS]
);
  import biu_mem_pkg::*;

  biu_if port_bus [PORTS] ();  // master side links
  biu_if mem_bus ();           // mux to memory

  genvar p;

  generate
    for (p = 0; p < PORTS; p++)
    begin : g_port
      // request side in
      assign port_bus[p].req   = req_i[p];
      assign port_bus[p].adri  = adri_i[p];
      assign port_bus[p].size  = size_i[p];
      assign port_bus[p].btype = type_i[p];
      assign port_bus[p].lock  = lock_i[p];
      assign port_bus[p].prot  = prot_i[p];
      assign port_bus[p].we    = we_i[p];
      assign port_bus[p].d     = d_i[p];

      // response side out
      assign req_ack_o[p] = port_bus[p].req_ack;
      assign d_ack_o[p]   = port_bus[p].d_ack;
      assign adro_o[p]    = port_bus[p].adro;
      assign q_o[p]       = port_bus[p].q;
      assign ack_o[p]     = port_bus[p].ack;
      assign err_o[p]     = port_bus[p].err;
    end
  endgenerate

  biu_mux u_mux
  (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .slv_i  (port_bus),
    .mst_o  (mem_bus)
  );

  biu_sram u_sram
  (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus_i  (mem_bus)
  );

endmodule

//--- logic/biu_sram.sv
`timescale 1ns/1ps
/*
  on-chip word memory acting as a BIU slave
  takes singles and INCR/WRAP bursts, one ack per beat with its address
  beats outside the array or with a non-word size return err and q zero
*/
module biu_sram
(
  input logic  clk_i,
  input logic  rst_ni,

  biu_if.slave bus_i
);
  import biu_constants_pkg::*;
  import biu_mem_pkg::*;

  logic [DATA_SIZE-1:0]         mem [MEM_WORDS];

  // burst control
  logic                         busy;
  logic [3:0]                   wait_cnt;   // idle cycles left
  logic [3:0]                   beat_cnt;   // beats left, minus one
  logic                         issue;      // a beat is served this cycle

  // burst attributes, latched on accept
  logic [ADDR_SIZE-1:0]         beat_adr;
  logic [3:0]                   blk_cnt;    // wrap block size in beats, minus one
  logic                         wrap;
  logic                         we;
  logic                         size_bad;

  logic [ADDR_SIZE-1:0]         wrap_mask;
  logic [ADDR_SIZE-1:0]         next_adr;
  logic                         beat_bad;
  logic [$clog2(MEM_WORDS)-1:0] beat_idx;

  // registered response
  logic                         ack_r;
  logic                         err_r;
  logic [ADDR_SIZE-1:0]         adro_r;
  logic [DATA_SIZE-1:0]         q_r;

  assign bus_i.req_ack = bus_i.req & ~busy;  // combinational accept
  assign issue         = busy & (wait_cnt == 4'd0);
  assign bus_i.d_ack   = issue & we;         // data taken one cycle ahead of ack

  //////////////////////////////
  // beat address

  assign wrap_mask = {{(ADDR_SIZE-6){1'b0}}, blk_cnt, 2'b11};  // 16, 32 or 64 byte block
  assign next_adr  = wrap ? ((beat_adr & ~wrap_mask) | ((beat_adr + ADDR_SIZE'(4)) & wrap_mask))
                          : beat_adr + ADDR_SIZE'(4);

  assign beat_idx = beat_adr[$clog2(MEM_WORDS)+1:2];
  assign beat_bad = size_bad | (beat_adr >= ADDR_SIZE'(MEM_WORDS * 4));

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      busy     <= 1'b0;
      wait_cnt <= 4'd0;
      beat_cnt <= 4'd0;
    end
    else if (bus_i.req_ack)
    begin
      busy     <= 1'b1;
      wait_cnt <= 4'(MEM_WAIT - 1);
      beat_cnt <= biu_type2cnt(bus_i.btype);
    end
    else if (busy)
    begin
      if (wait_cnt != 4'd0)
        wait_cnt <= wait_cnt - 4'd1;
      else if (beat_cnt == 4'd0)
        busy <= 1'b0;                        // last beat issued
      else
        beat_cnt <= beat_cnt - 4'd1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (bus_i.req_ack)
    begin
      beat_adr <= bus_i.adri;
      blk_cnt  <= biu_type2cnt(bus_i.btype);
      wrap     <= bus_i.btype inside {WRAP4, WRAP8, WRAP16};
      we       <= bus_i.we;
      size_bad <= (bus_i.size != WORD);     // no byte lanes
    end
    else if (issue)
      beat_adr <= next_adr;
  end

  //////////////////////////////
  // array and response

  always_ff @(posedge clk_i)
  begin
    if (issue && we && !beat_bad)
      mem[beat_idx] <= bus_i.d;
  end

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ack_r <= 1'b0;
      err_r <= 1'b0;
    end
    else
    begin
      ack_r <= issue;
      err_r <= issue & beat_bad;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (issue)
    begin
      adro_r <= beat_adr;
      q_r    <= beat_bad ? '0 : mem[beat_idx];  // old contents on a write
    end
  end

  assign bus_i.ack  = ack_r;
  assign bus_i.err  = err_r;
  assign bus_i.adro = adro_r;
  assign bus_i.q    = q_r;

endmodule

//--- run.sh
#!/bin/sh
# build and run the BIU memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -f files.f --top-module biu_mux_tb -o biu_mux_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/biu_mux_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
  echo "no pass message in $LOG"
  exit 1
fi
exit 0

//--- test/biu_mux_tb_model.svh
/*
  reference model for the BIU memory subsystem testbench
  included inside the testbench module body, after its imports and seed
  holds the expected array, the beat rules and the stimulus patterns
*/
`ifndef BIU_MUX_TB_MODEL_SVH
`define BIU_MUX_TB_MODEL_SVH

logic [DATA_SIZE-1:0] ref_mem [MEM_WORDS];  // expected array contents

// beats per burst, undefined length INCR counts as one
function automatic int beats_of(input biu_type_t btype);
  case (btype)
    INCR4, WRAP4   : return 4;
    INCR8, WRAP8   : return 8;
    INCR16, WRAP16 : return 16;
    default        : return 1;
  endcase
endfunction

// address of beat k, WRAP stays inside an aligned block of beats * 4 bytes
function automatic logic [ADDR_SIZE-1:0] beat_addr(input logic [ADDR_SIZE-1:0] adr,
                                                   input biu_type_t btype, input int k);
  logic [ADDR_SIZE-1:0] span;
  span = ADDR_SIZE'(beats_of(btype) * 4);
  if (btype inside {WRAP4, WRAP8, WRAP16})
    return (adr & ~(span - 1)) | ((adr + ADDR_SIZE'(4 * k)) & (span - 1));
  return adr + ADDR_SIZE'(4 * k);
endfunction

// error rule, word size only and inside the array
function automatic logic fails_rule(input logic [ADDR_SIZE-1:0] adr, input biu_size_t size);
  return (size != WORD) || (adr >= ADDR_SIZE'(MEM_WORDS * 4));
endfunction

function automatic logic [$clog2(MEM_WORDS)-1:0] word_idx(input logic [ADDR_SIZE-1:0] adr);
  return adr[$clog2(MEM_WORDS)+1:2];
endfunction

// write data, a function of the whole beat address
function automatic logic [DATA_SIZE-1:0] data_pattern(input logic [ADDR_SIZE-1:0] adr,
                                                      input logic [DATA_SIZE-1:0] salt);
  return (adr * 32'h2545_f491) ^ {adr[15:0], adr[31:16]} ^ salt;
endfunction

// word aligned, now and then past the top of the memory
function automatic logic [ADDR_SIZE-1:0] rand_addr();
  logic [ADDR_SIZE-1:0] r;
  r = $random(seed);
  return (r % ADDR_SIZE'(MEM_WORDS * 4 + 64)) & ~ADDR_SIZE'(3);
endfunction

`endif

//--- test/biu_mux_tb.sv
`timescale 1ns/1ps
/*
  testbench for the two port BIU memory subsystem
  drives both masters through singles, bursts, contention, error beats
  and random traffic; every beat is checked against a reference memory
*/
module biu_mux_tb;
  import biu_constants_pkg::*;
  import biu_mem_pkg::*;

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 5;
  localparam int RAND_XFERS     = 20;                        // per port
  localparam int DIRECTED_BEATS = 4 + 112 + 16 + 17 + 18;    // tests 1 to 5
  localparam int PLANNED_BEATS  = 2 * MEM_WORDS + DIRECTED_BEATS + 2 * RAND_XFERS * 16;
  localparam int WATCHDOG_CYCLES = PLANNED_BEATS * 20 + RESET_CYCLES;

  typedef struct packed {
    logic [7:0]           port;
    logic [ADDR_SIZE-1:0] adr;
    logic [DATA_SIZE-1:0] q;
    logic                 err;
    logic                 chk_q;   // q only defined on reads and failed beats
  } beat_t;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req_i     [PORTS];
  logic                 req_ack_o [PORTS];
  logic                 d_ack_o   [PORTS];
  logic [ADDR_SIZE-1:0] adri_i    [PORTS];
  logic [ADDR_SIZE-1:0] adro_o    [PORTS];
  biu_size_t            size_i    [PORTS];
  biu_type_t            type_i    [PORTS];
  logic                 lock_i    [PORTS];
  biu_prot_t            prot_i    [PORTS];
  logic                 we_i      [PORTS];
  logic [DATA_SIZE-1:0] d_i       [PORTS];
  logic [DATA_SIZE-1:0] q_o       [PORTS];
  logic                 ack_o     [PORTS];
  logic                 err_o     [PORTS];

  int        seed;
  int        mismatches;
  int        faults;
  int        rem [PORTS];                 // beats left per port, monitor view
  beat_t     exp_beats [$];
  beat_t     obs_beats [$];
  beat_t     ob;
  beat_t     eb;
  biu_type_t burst_set [6] = '{INCR4, INCR8, INCR16, WRAP4, WRAP8, WRAP16};

  `include "biu_mux_tb_model.svh"

  biu_mux_top dut0
  (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .req_ack_o (req_ack_o),
    .d_ack_o   (d_ack_o),
    .adri_i    (adri_i),
    .adro_o    (adro_o),
    .size_i    (size_i),
    .type_i    (type_i),
    .lock_i    (lock_i),
    .prot_i    (prot_i),
    .we_i      (we_i),
    .d_i       (d_i),
    .q_o       (q_o),
    .ack_o     (ack_o),
    .err_o     (err_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////
  // compare tasks

  task automatic addr_cmp(input string name, input logic [ADDR_SIZE-1:0] got, exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic data_cmp(input string name, input logic [DATA_SIZE-1:0] got, exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic flag_cmp(input string name, input logic got, exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_fault(input string msg);
    faults++;
    $display("%s", msg);
  endtask

  //////////////////////////////
  // expected beats, taken in acceptance order

  function automatic void expect_burst(input int p, input logic [ADDR_SIZE-1:0] adr,
                                       input biu_size_t size, input biu_type_t btype,
                                       input logic we, input logic [DATA_SIZE-1:0] salt);
    beat_t b;
    int    k;
    for (k = 0; k < beats_of(btype); k++)
    begin
      b.port  = 8'(p);
      b.adr   = beat_addr(adr, btype, k);
      b.err   = fails_rule(b.adr, size);
      b.chk_q = !we || b.err;
      b.q     = b.err ? '0 : ref_mem[word_idx(b.adr)];   // old word on a write
      if (we && !b.err)
        ref_mem[word_idx(b.adr)] = data_pattern(b.adr, salt);
      exp_beats.push_back(b);
    end
  endfunction

  // one transfer on port p, returns after its last ack
  task automatic run_xfer(input int p, input logic [ADDR_SIZE-1:0] adr, input biu_size_t size,
                          input biu_type_t btype, input logic we,
                          input logic [DATA_SIZE-1:0] salt);
    beat_t b;
    int    nb;
    int    k;
    int    got;
    nb  = beats_of(btype);
    k   = 0;
    got = 0;
    @(posedge clk_i);
    req_i[p]  <= 1'b1;
    adri_i[p] <= adr;
    size_i[p] <= size;
    type_i[p] <= btype;
    we_i[p]   <= we;
    d_i[p]    <= data_pattern(adr, salt);  // beat 0 sits at the start address
    while (got < nb)
    begin
      @(posedge clk_i);
      if (req_i[p] && req_ack_o[p])
      begin
        req_i[p] <= 1'b0;
        expect_burst(p, adr, size, btype, we, salt);
      end
      if (d_ack_o[p] && k < nb - 1)      // next write word
      begin
        k++;
        d_i[p] <= data_pattern(beat_addr(adr, btype, k), salt);
      end
      if (ack_o[p])
      begin
        b.port  = 8'(p);
        b.adr   = adro_o[p];
        b.q     = q_o[p];
        b.err   = err_o[p];
        b.chk_q = 1'b0;
        obs_beats.push_back(b);
        got++;
      end
    end
  endtask

  task automatic random_traffic(input int p);
    biu_type_t t;
    biu_size_t s;
    logic      w;
    int        i;
    for (i = 0; i < RAND_XFERS; i++)
    begin
      repeat ({$random(seed)} % 4) @(posedge clk_i);
      t = biu_type_t'(3'($random(seed)));
      s = (3'($random(seed)) == 3'd0) ? HWORD : WORD;   // one in eight bad size
      w = 1'($random(seed));
      run_xfer(p, rand_addr(), s, t, w, $random(seed));
    end
  endtask

  //////////////////////////////
  // beat compare, away from the active edge

  always @(negedge clk_i)
  begin
    while (obs_beats.size() > 0 && exp_beats.size() > 0)
    begin
      ob = obs_beats.pop_front();
      eb = exp_beats.pop_front();
      if (ob.port != eb.port)
        report_fault($sformatf("beat for port %0d arrived on port %0d", eb.port, ob.port));
      addr_cmp("adro_o", ob.adr, eb.adr);
      flag_cmp("err_o", ob.err, eb.err);
      if (eb.chk_q)
        data_cmp("q_o", ob.q, eb.q);
    end
  end

  // strobe ownership, priority and handover
  always @(posedge clk_i)
  begin : protocol_monitor
    int p;
    int n;
    int first_req;
    if (rst_ni)
    begin
      first_req = -1;
      for (n = PORTS - 1; n >= 0; n--)
        if (req_i[n])
          first_req = n;
      for (p = 0; p < PORTS; p++)
      begin
        if ((d_ack_o[p] || ack_o[p] || err_o[p]) && rem[p] == 0)
          report_fault($sformatf("port %0d got a strobe outside its own burst", p));
        if (req_ack_o[p] && (!req_i[p] || first_req != p))
          report_fault($sformatf("port %0d accepted without being first in line", p));
        for (n = 0; n < PORTS; n++)
          if (req_ack_o[p] && n != p && rem[n] > 0 && !(rem[n] == 1 && ack_o[n]))
            report_fault($sformatf("port %0d accepted during a burst of port %0d", p, n));
        if (ack_o[p] && rem[p] == 1 && first_req >= 0 && !req_ack_o[first_req])
          report_fault($sformatf("port %0d not served after the burst of port %0d",
                                 first_req, p));
      end
      for (p = 0; p < PORTS; p++)
      begin
        if (ack_o[p] && rem[p] > 0)
          rem[p] = rem[p] - 1;
        if (req_ack_o[p])
          rem[p] = beats_of(type_i[p]);
      end
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout, run still busy after %0d cycles", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  //////////////////////////////
  // test sequence

  initial
  begin : sequence_main
    int i;
    int k;
    seed       = 24359;
    mismatches = 0;
    faults     = 0;
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    for (i = 0; i < PORTS; i++)
    begin
      req_i[i]  = 1'b0;
      adri_i[i] = '0;
      size_i[i] = WORD;
      type_i[i] = SINGLE;
      lock_i[i] = 1'b0;
      prot_i[i] = (i == 0) ? PROT_INSTR : PROT_DATA;  // instruction port first
      we_i[i]   = 1'b0;
      d_i[i]    = '0;
      rem[i]    = 0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (i = 0; i < MEM_WORDS / 16; i++)     // known contents everywhere
      run_xfer(0, ADDR_SIZE'(64 * i), WORD, INCR16, 1'b1, '0);

    for (i = 0; i < PORTS; i++)              // 1: singles per port
    begin
      run_xfer(i, ADDR_SIZE'(32'h10 + 8 * i), WORD, SINGLE, 1'b1, $random(seed));
      run_xfer(i, ADDR_SIZE'(32'h10 + 8 * i), WORD, SINGLE, 1'b0, '0);
    end

    for (i = 0; i < 6; i++)                  // 2: every burst, then single reads
    begin
      run_xfer(i % 2, ADDR_SIZE'(32'h108 + 64 * i), WORD, burst_set[i], 1'b1, $random(seed));
      for (k = 0; k < beats_of(burst_set[i]); k++)
        run_xfer((i + 1) % 2, beat_addr(ADDR_SIZE'(32'h108 + 64 * i), burst_set[i], k),
                 WORD, SINGLE, 1'b0, '0);
    end

    fork                                     // 3: same cycle requests
      run_xfer(0, 32'h200, WORD, INCR8, 1'b1, $random(seed));
      run_xfer(1, 32'h208, WORD, WRAP8, 1'b0, '0);
    join

    fork                                     // 4: port 0 arrives mid burst
      run_xfer(1, 32'h300, WORD, INCR16, 1'b1, $random(seed));
      begin
        repeat (6) @(posedge clk_i);
        run_xfer(0, 32'h304, WORD, SINGLE, 1'b0, '0);
      end
    join

    run_xfer(0, 32'h3f8, WORD, INCR4, 1'b1, $random(seed));  // 5: crosses the top
    run_xfer(1, 32'h800, WORD, SINGLE, 1'b0, '0);
    run_xfer(0, 32'h48, BYTE, WRAP4, 1'b1, $random(seed));
    run_xfer(1, 32'h40, HWORD, SINGLE, 1'b0, '0);
    run_xfer(1, 32'h40, WORD, INCR4, 1'b0, '0);               // untouched by the errors
    run_xfer(0, 32'h3f8, WORD, INCR4, 1'b0, '0);

    fork                                     // 6: random on both ports
      random_traffic(0);
      random_traffic(1);
    join

    for (i = 0; i < MEM_WORDS / 16; i++)     // whole array read back
      run_xfer(1, ADDR_SIZE'(64 * i), WORD, INCR16, 1'b0, '0);

    repeat (4) @(posedge clk_i);
    if (exp_beats.size() != 0 || obs_beats.size() != 0)
      report_fault($sformatf("%0d expected and %0d observed beats left unmatched",
                             exp_beats.size(), obs_beats.size()));
    $display("errors: %0d mismatches, %0d protocol faults", mismatches, faults);
    if (mismatches == 0 && faults == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule
